// ==== rtl/rv32_pkg.sv ====
// RV32I shared package with word types, opcodes and the decode and control enums
package rv32_pkg;

  // Plain vector types
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [6:0]  opcode_t;

  // Major opcodes, instr[6:0]
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // Values follow funct3 of the branch opcode
  typedef enum logic [2:0] {
    BEQ = 3'b000, BNE = 3'b001, BLT = 3'b100,
    BGE = 3'b101, BLTU = 3'b110, BGEU = 3'b111
  } branch_type_t;

  // Values follow funct3, stores reuse LB, LH and LW
  typedef enum logic [2:0] {
    LB = 3'b000, LH = 3'b001, LW = 3'b010, LBU = 3'b100, LHU = 3'b101
  } load_type_t;

  typedef enum logic {A_RS1, A_PC} alu_a_sel_t;

  typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_S, B_IMM_U} alu_b_sel_t;

  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4, WB_IMM_U} wb_sel_t;

  // Wishbone master states
  typedef enum logic {LSU_IDLE, LSU_WAIT} lsu_state_t;

endpackage

// ==== rtl/control_unit.sv ====
// RV32I decoder producing immediates, operand and write-back selects and exception flags
`timescale 1ns/100ps

module control_unit import rv32_pkg::*; (
  input  word_t      instr,
  output word_t      imm_i,
  output word_t      imm_s,
  output word_t      imm_b,
  output word_t      imm_j,
  output word_t      imm_u,
  output alu_op_t    alu_op,
  output alu_a_sel_t alu_a_sel,
  output alu_b_sel_t alu_b_sel,
  output wb_sel_t    wb_sel,
  output load_type_t load_type,
  output reg_idx_t   rd,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output logic       wen,
  output logic       dren,
  output logic       dwen,
  output logic       branch,
  output logic       jump,
  output logic       jalr,
  output logic       halt,
  output logic       illegal_insn
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Shared ALU op decode for register and immediate forms
  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign load_type = load_type_t'(funct3);

  // Sign-extended immediates for every format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    alu_op       = ALU_ADD;
    alu_a_sel    = A_RS1;
    alu_b_sel    = B_IMM_I;
    wb_sel       = WB_ALU;
    wen          = 1'b0;
    dren         = 1'b0;
    dwen         = 1'b0;
    branch       = 1'b0;
    jump         = 1'b0;
    jalr         = 1'b0;
    halt         = 1'b0;
    illegal_insn = 1'b0;
    case (opcode)
      OP_LUI: begin
        wen    = 1'b1;
        wb_sel = WB_IMM_U;
      end
      OP_AUIPC: begin
        wen       = 1'b1;
        alu_a_sel = A_PC;
        alu_b_sel = B_IMM_U;
      end
      OP_JAL: begin
        wen    = 1'b1;
        jump   = 1'b1;
        wb_sel = WB_PC4;
      end
      OP_JALR: begin
        wen          = 1'b1;
        jump         = 1'b1;
        jalr         = 1'b1;
        wb_sel       = WB_PC4;
        illegal_insn = (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        branch = 1'b1;
        // funct3 010 and 011 are unassigned
        illegal_insn = (funct3[2:1] == 2'b01);
      end
      OP_LOAD: begin
        wen    = 1'b1;
        dren   = 1'b1;
        wb_sel = WB_LOAD;
        illegal_insn = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      OP_STORE: begin
        dwen      = 1'b1;
        alu_b_sel = B_IMM_S;
        illegal_insn = (funct3[2] || funct3 == 3'b011);
      end
      OP_IMM: begin
        wen = 1'b1;
        // Only SRAI takes the alternate bit, as ADDI has no SUB form
        alu_op = alu_decode(funct3, instr[30] && funct3 == 3'b101);
        if (funct3 == 3'b001) begin
          illegal_insn = (funct7 != 7'b0);
        end else if (funct3 == 3'b101) begin
          illegal_insn = (funct7 != 7'b0) && (funct7 != 7'b0100000);
        end
      end
      OP_REG: begin
        wen       = 1'b1;
        alu_b_sel = B_RS2;
        alu_op    = alu_decode(funct3, instr[30]);
        illegal_insn = (funct7 != 7'b0) &&
                       !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OP_SYSTEM: begin
        // ECALL and EBREAK stop the core, CSR access is not supported
        halt         = (instr == 32'h0000_0073) || (instr == 32'h0010_0073);
        illegal_insn = !halt;
      end
      default: illegal_insn = 1'b1;
    endcase
    // Illegal encodings must leave no side effect
    if (illegal_insn) begin
      wen    = 1'b0;
      dren   = 1'b0;
      dwen   = 1'b0;
      branch = 1'b0;
      jump   = 1'b0;
      jalr   = 1'b0;
      halt   = 1'b0;
    end
  end

  // A single decode never issues both a load and a store
  always_comb begin
    assert (!(dren && dwen)) else $error("load and store decoded together");
  end

endmodule

// ==== rtl/reg_file.sv ====
// 32-entry integer register file with two async reads and one sync write, x0 fixed at zero
`timescale 1ns/100ps

module reg_file import rv32_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     wen,
  input  word_t    w_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      // x0 is never written so it reads back zero
      regs[rd] <= w_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

// ==== rtl/alu.sv ====
// RV32I integer ALU covering add, sub, logic, shifts and set-less-than
`timescale 1ns/100ps

module alu import rv32_pkg::*; (
  input  alu_op_t alu_op,
  input  word_t   port_a,
  input  word_t   port_b,
  output word_t   port_out
);

  logic [4:0] shamt;

  // Shift amount is the low five bits only
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  port_out = port_a + port_b;
      ALU_SUB:  port_out = port_a - port_b;
      ALU_AND:  port_out = port_a & port_b;
      ALU_OR:   port_out = port_a | port_b;
      ALU_XOR:  port_out = port_a ^ port_b;
      ALU_SLL:  port_out = port_a << shamt;
      ALU_SRL:  port_out = port_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  port_out = word_t'($signed(port_a) >>> shamt);
      ALU_SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: port_out = {31'b0, port_a < port_b};
      default:  port_out = '0;
    endcase
  end

endmodule

// ==== rtl/branch_res.sv ====
// Branch condition check and branch, JAL and JALR target calculation
`timescale 1ns/100ps

module branch_res import rv32_pkg::*; (
  input  word_t        rs1_data,
  input  word_t        rs2_data,
  input  word_t        pc,
  input  word_t        imm_b,
  input  word_t        imm_j,
  input  word_t        imm_i,
  input  branch_type_t branch_type,
  input  logic         branch,
  input  logic         jump,
  input  logic         jalr,
  output logic         taken,
  output word_t        target
);

  logic cond;
  word_t jalr_sum;

  always_comb begin
    case (branch_type)
      BEQ:     cond = (rs1_data == rs2_data);
      BNE:     cond = (rs1_data != rs2_data);
      BLT:     cond = ($signed(rs1_data) < $signed(rs2_data));
      BGE:     cond = ($signed(rs1_data) >= $signed(rs2_data));
      BLTU:    cond = (rs1_data < rs2_data);
      BGEU:    cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  // Jumps are unconditional
  assign taken = jump | (branch & cond);

  // JALR drops bit 0 of the sum
  assign jalr_sum = rs1_data + imm_i;

  always_comb begin
    if (jalr) target = {jalr_sum[31:1], 1'b0};
    else if (jump) target = pc + imm_j;
    else target = pc + imm_b;
  end

endmodule

// ==== rtl/load_store_unit.sv ====
// Load/store unit with lane steering, misalignment check and a Wishbone classic master
`timescale 1ns/100ps

module load_store_unit import rv32_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       dren,
  input  logic       dwen,
  input  word_t      addr,
  input  word_t      store_data,
  input  load_type_t load_type,
  input  word_t      dat_r,
  input  logic       ack,
  output logic       cyc,
  output logic       stb,
  output logic       we,
  output word_t      adr,
  output byte_en_t   sel,
  output word_t      dat_w,
  output word_t      load_data,
  output logic       busy,
  output logic       done,
  output logic       mal_load,
  output logic       mal_store
);

  lsu_state_t state, next_state;
  logic [1:0] offset;
  logic       misaligned;
  logic       req;
  word_t      shifted;

  assign offset = addr[1:0];

  // Stores share the load encoding for lane enables
  always_comb begin
    case (load_type)
      LB, LBU: sel = byte_en_t'(4'b0001 << offset);
      LH, LHU: sel = offset[1] ? 4'b1100 : 4'b0011;
      LW:      sel = 4'b1111;
      default: sel = 4'b0000;
    endcase
  end

  // Word needs offset 0 and half needs an even offset
  assign misaligned = (load_type == LW && offset != 2'b00) ||
                      ((load_type == LH || load_type == LHU) && offset[0]);
  assign mal_load  = dren & misaligned;
  assign mal_store = dwen & misaligned;
  assign req       = (dren | dwen) & ~misaligned;

  // Replicate narrow store data so every lane holds it
  always_comb begin
    case (load_type)
      LB:      dat_w = {4{store_data[7:0]}};
      LH:      dat_w = {2{store_data[15:0]}};
      default: dat_w = store_data;
    endcase
  end

  // Bring the addressed lane down to bit 0 and extend it
  assign shifted = dat_r >> {offset, 3'b000};
  always_comb begin
    case (load_type)
      LB:      load_data = {{24{shifted[7]}}, shifted[7:0]};
      LBU:     load_data = {24'b0, shifted[7:0]};
      LH:      load_data = {{16{shifted[15]}}, shifted[15:0]};
      LHU:     load_data = {16'b0, shifted[15:0]};
      default: load_data = dat_r;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) state <= LSU_IDLE;
    else state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      LSU_IDLE: if (req && !ack) next_state = LSU_WAIT;
      LSU_WAIT: if (ack) next_state = LSU_IDLE;
      default:  next_state = LSU_IDLE;
    endcase
  end

  // Cycle opens combinationally so the slave sees it at the first edge
  assign cyc  = (state == LSU_WAIT) | req;
  assign stb  = cyc;
  assign we   = dwen;
  assign adr  = {addr[31:2], 2'b00};
  assign busy = cyc & ~ack;
  assign done = cyc & ack;

  // Strobe only inside a bus cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) $rose(stb) |-> cyc);

  // Address and data stay put until the slave answers
  a_hold: assert property (@(posedge clk) disable iff (rst)
    cyc && !ack |=> cyc && $stable(adr) && $stable(dat_w) && $stable(sel));

endmodule

// ==== rtl/execute_stage.sv ====
// Execute stage with decode, register file, ALU, branch resolution and load/store
`timescale 1ns/100ps

module execute_stage import rv32_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     instr_valid,
  input  word_t    instr,
  input  word_t    pc,
  input  word_t    pc4,
  input  logic     prediction,
  output logic     cyc,
  output logic     stb,
  output logic     we,
  output word_t    adr,
  output byte_en_t sel,
  output word_t    dat_w,
  input  word_t    dat_r,
  input  logic     ack,
  output logic     ready,
  output word_t    redirect_addr,
  output logic     mispredict,
  output logic     commit_valid,
  output reg_idx_t commit_rd,
  output word_t    commit_data,
  output logic     halt,
  output logic     illegal_insn,
  output logic     mal_load,
  output logic     mal_store
);

  word_t imm_i, imm_s, imm_b, imm_j, imm_u;
  alu_op_t alu_op;
  alu_a_sel_t alu_a_sel;
  alu_b_sel_t alu_b_sel;
  wb_sel_t wb_sel;
  load_type_t load_type;
  reg_idx_t rd, rs1, rs2;
  logic cu_wen, cu_dren, cu_dwen, cu_branch, cu_jump, cu_jalr, cu_halt, cu_illegal;
  word_t rs1_data, rs2_data, w_data;
  word_t port_a, port_b, alu_out;
  logic taken;
  word_t target, load_data;
  logic lsu_busy, lsu_done;
  logic rf_wen;

  control_unit i_control_unit (
    .instr, .imm_i, .imm_s, .imm_b, .imm_j, .imm_u, .alu_op, .alu_a_sel, .alu_b_sel,
    .wb_sel, .load_type, .rd, .rs1, .rs2, .wen(cu_wen), .dren(cu_dren), .dwen(cu_dwen),
    .branch(cu_branch), .jump(cu_jump), .jalr(cu_jalr), .halt(cu_halt),
    .illegal_insn(cu_illegal)
  );

  reg_file i_reg_file (
    .clk, .rst, .rs1, .rs2, .rd, .wen(rf_wen), .w_data, .rs1_data, .rs2_data
  );

  // Operand muxes
  assign port_a = (alu_a_sel == A_PC) ? pc : rs1_data;
  always_comb begin
    case (alu_b_sel)
      B_RS2:   port_b = rs2_data;
      B_IMM_I: port_b = imm_i;
      B_IMM_S: port_b = imm_s;
      default: port_b = imm_u;
    endcase
  end

  alu i_alu (.alu_op, .port_a, .port_b, .port_out(alu_out));

  // Branch type is funct3 itself
  branch_res i_branch_res (
    .rs1_data, .rs2_data, .pc, .imm_b, .imm_j, .imm_i,
    .branch_type(branch_type_t'(instr[14:12])), .branch(cu_branch), .jump(cu_jump),
    .jalr(cu_jalr), .taken, .target
  );

  // Requests only go out for a valid instruction
  load_store_unit i_load_store_unit (
    .clk, .rst, .dren(cu_dren & instr_valid), .dwen(cu_dwen & instr_valid),
    .addr(alu_out), .store_data(rs2_data), .load_type, .dat_r, .ack, .cyc, .stb, .we,
    .adr, .sel, .dat_w, .load_data, .busy(lsu_busy), .done(lsu_done), .mal_load, .mal_store
  );

  always_comb begin
    case (wb_sel)
      WB_ALU:  w_data = alu_out;
      WB_LOAD: w_data = load_data;
      WB_PC4:  w_data = pc4;
      default: w_data = imm_u;
    endcase
  end

  // Loads write back only in the ack cycle
  assign rf_wen = cu_wen & instr_valid & ~lsu_busy & ~mal_load & (~cu_dren | lsu_done);

  assign ready         = ~lsu_busy;
  assign redirect_addr = taken ? target : pc4;
  assign mispredict    = instr_valid & (cu_branch | cu_jump) & (prediction ^ taken);
  assign commit_valid  = rf_wen;
  assign commit_rd     = rd;
  assign commit_data   = w_data;
  assign halt          = cu_halt & instr_valid;
  assign illegal_insn  = cu_illegal & instr_valid;

endmodule

// ==== rtl/data_ram.sv ====
// Wishbone classic slave RAM with byte-lane writes and a one-cycle registered ack
`timescale 1ns/100ps

module data_ram import rv32_pkg::*; #(
  parameter int ram_words = 256
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     cyc,
  input  logic     stb,
  input  logic     we,
  input  word_t    adr,
  input  byte_en_t sel,
  input  word_t    dat_w,
  output word_t    dat_r,
  output logic     ack
);

  localparam int idx_w = $clog2(ram_words);

  word_t mem [ram_words];
  logic [idx_w-1:0] idx;
  logic access;

  // Byte address to word index
  assign idx    = adr[idx_w+1:2];
  assign access = cyc & stb & ~ack;

  // Ack goes high once per request and drops the next cycle
  always_ff @(posedge clk) begin
    if (rst) ack <= 1'b0;
    else ack <= access;
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (sel[b]) mem[idx][b*8 +: 8] <= dat_w[b*8 +: 8];
        end
      end
      dat_r <= mem[idx];
    end
  end

endmodule

// ==== rtl/exec_subsystem_top.sv ====
// Standalone execute subsystem joining the execute stage to its data RAM
`timescale 1ns/100ps

module exec_subsystem_top import rv32_pkg::*; #(
  parameter int ram_words = 256
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     instr_valid,
  input  word_t    instr,
  input  word_t    pc,
  input  word_t    pc4,
  input  logic     prediction,
  output logic     ready,
  output word_t    redirect_addr,
  output logic     mispredict,
  output logic     commit_valid,
  output reg_idx_t commit_rd,
  output word_t    commit_data,
  output logic     halt,
  output logic     illegal_insn,
  output logic     mal_load,
  output logic     mal_store
);

  // Wishbone link between stage and RAM
  logic wb_cyc, wb_stb, wb_we, wb_ack;
  word_t wb_adr, wb_dat_w, wb_dat_r;
  byte_en_t wb_sel;

  execute_stage i_execute_stage (
    .clk, .rst, .instr_valid, .instr, .pc, .pc4, .prediction,
    .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr), .sel(wb_sel),
    .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack),
    .ready, .redirect_addr, .mispredict, .commit_valid, .commit_rd, .commit_data,
    .halt, .illegal_insn, .mal_load, .mal_store
  );

  data_ram #(.ram_words(ram_words)) i_data_ram (
    .clk, .rst, .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr), .sel(wb_sel),
    .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack)
  );

endmodule

// ==== tb/tb_exec.sv ====
// Self-checking testbench for the execute subsystem, replaying golden instruction vectors
`timescale 1ns/100ps

module tb_exec;

  localparam int    clk_period  = 40;
  localparam string golden_path = "tb/exec_golden.txt";

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] pc4;
  logic        prediction;
  logic        ready;
  logic [31:0] redirect_addr;
  logic        mispredict;
  logic        commit_valid;
  logic [4:0]  commit_rd;
  logic [31:0] commit_data;
  logic        halt;
  logic        illegal_insn;
  logic        mal_load;
  logic        mal_store;

  // One queue per golden column
  logic [31:0] q_instr [$];
  logic [31:0] q_pc    [$];
  logic [31:0] q_pred  [$];
  logic [31:0] q_cv    [$];
  logic [31:0] q_rd    [$];
  logic [31:0] q_data  [$];
  logic [31:0] q_redir [$];
  logic [31:0] q_mp    [$];
  logic [31:0] q_exc   [$];

  int value_errors;
  int other_errors;
  int num_lines;
  int accept_cycles;
  bit lines_loaded;

  exec_subsystem_top i_exec_subsystem_top (
    .clk, .rst, .instr_valid, .instr, .pc, .pc4, .prediction,
    .ready, .redirect_addr, .mispredict, .commit_valid, .commit_rd, .commit_data,
    .halt, .illegal_insn, .mal_load, .mal_store
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Compare one output against its golden value
  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int idx);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED t=%0t %s expected %h got %h (vector %0d)", $time, name, exp, got, idx);
    end
  endtask

  // Aligned loads and stores hold ready low for one cycle before the ack cycle
  function automatic int expected_cycles(input logic [31:0] instr_word,
                                         input logic [31:0] exc_code);
    logic [6:0] opc;
    opc = instr_word[6:0];
    if (exc_code == 0 && (opc == 7'b0000011 || opc == 7'b0100011)) begin
      return 2;
    end else begin
      return 1;
    end
  endfunction

  // Loads every vector line and skips lines starting with #
  task automatic read_golden();
    int fd;
    int count;
    string line;
    logic [31:0] v_instr, v_pc, v_pred, v_cv, v_rd, v_data, v_redir, v_mp, v_exc;
    fd = $fopen(golden_path, "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open %s for reading", golden_path);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          count = $sscanf(line, "%h %h %h %h %h %h %h %h %h", v_instr, v_pc, v_pred,
                          v_cv, v_rd, v_data, v_redir, v_mp, v_exc);
          if (count != 9) begin
            other_errors++;
            $display("Golden line could not be parsed: %s", line);
          end else begin
            q_instr.push_back(v_instr);
            q_pc.push_back(v_pc);
            q_pred.push_back(v_pred);
            q_cv.push_back(v_cv);
            q_rd.push_back(v_rd);
            q_data.push_back(v_data);
            q_redir.push_back(v_redir);
            q_mp.push_back(v_mp);
            q_exc.push_back(v_exc);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Exception code 1 illegal, 2 mal_load, 3 mal_store, 4 halt
  task automatic check_outputs(input int idx);
    logic [2:0] exc;
    exc = q_exc[idx][2:0];
    compare_field("commit_valid", 32'(commit_valid), q_cv[idx], idx);
    // rd and data only mean something on a commit
    if (q_cv[idx][0]) begin
      compare_field("commit_rd", 32'(commit_rd), q_rd[idx], idx);
      compare_field("commit_data", commit_data, q_data[idx], idx);
    end
    compare_field("redirect_addr", redirect_addr, q_redir[idx], idx);
    compare_field("mispredict", 32'(mispredict), q_mp[idx], idx);
    compare_field("illegal_insn", 32'(illegal_insn), 32'(exc == 3'd1), idx);
    compare_field("mal_load", 32'(mal_load), 32'(exc == 3'd2), idx);
    compare_field("mal_store", 32'(mal_store), 32'(exc == 3'd3), idx);
    compare_field("halt", 32'(halt), 32'(exc == 3'd4), idx);
  endtask

  initial begin
    rst          = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    pc           = '0;
    pc4          = '0;
    prediction   = 1'b0;
    value_errors = 0;
    other_errors = 0;
    lines_loaded = 1'b0;
    read_golden();
    num_lines = q_instr.size();
    if (num_lines == 0) begin
      other_errors++;
      $display("Golden file holds no vectors");
    end
    lines_loaded = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < num_lines; i++) begin
      // Previous accept edge doubles as the launch edge of the next vector
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= q_instr[i];
      pc          <= q_pc[i];
      pc4         <= q_pc[i] + 32'd4;
      prediction  <= q_pred[i][0];
      // Sample mid-cycle until ready marks the accept cycle
      accept_cycles = 0;
      do begin
        @(negedge clk);
        accept_cycles++;
      end while (!ready);
      compare_field("ready cycles", 32'(accept_cycles),
                    32'(expected_cycles(q_instr[i], q_exc[i])), i);
      check_outputs(i);
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    repeat (2) @(posedge clk);
    $display("Run over %0d vectors: %0d value errors, %0d other errors",
             num_lines, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Budget of four cycles per vector plus reset and drain
  initial begin
    wait (lines_loaded);
    #((num_lines * 4 + 20) * clk_period);
    $display("Watchdog expired before all vectors were accepted");
    $display("Run over %0d vectors: %0d value errors, %0d other errors",
             num_lines, value_errors, other_errors + 1);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== tb/exec_golden.txt ====
# instr pc prediction | commit_valid commit_rd commit_data | redirect_addr mispredict | exc
# exc code 0 none, 1 illegal, 2 mal_load, 3 mal_store, 4 halt; all columns hex
00500093 00000100 0 1 01 00000005 00000104 0 0
FFD00113 00000104 0 1 02 FFFFFFFD 00000108 0 0
002081B3 00000108 0 1 03 00000002 0000010C 0 0
40208233 0000010C 0 1 04 00000008 00000110 0 0
0020C2B3 00000110 0 1 05 FFFFFFF8 00000114 0 0
00409413 00000114 0 1 08 00000050 00000118 0 0
40115493 00000118 0 1 09 FFFFFFFE 0000011C 0 0
001125B3 0000011C 0 1 0B 00000001 00000120 0 0
123456B7 00000120 0 1 0D 12345000 00000124 0 0
00001717 00000124 0 1 0E 00001124 00000128 0 0
00708013 00000128 0 1 00 0000000C 0000012C 0 0
001007B3 0000012C 0 1 0F 00000005 00000130 0 0
04D02023 00000130 0 0 00 00000000 00000134 0 0
042000A3 00000134 0 0 00 00000000 00000138 0 0
04401123 00000138 0 0 00 00000000 0000013C 0 0
04100803 0000013C 0 1 10 FFFFFFFD 00000140 0 0
04104883 00000140 0 1 11 000000FD 00000144 0 0
04001903 00000144 0 1 12 FFFFFD00 00000148 0 0
04205983 00000148 0 1 13 00000008 0000014C 0 0
04102A83 0000014C 0 0 00 00000000 00000150 0 2
041011A3 00000150 0 0 00 00000000 00000154 0 3
04002B03 00000154 0 1 16 0008FD00 00000158 0 0
00F08863 00000158 0 0 00 00000000 00000168 1 0
FEF09CE3 0000015C 1 0 00 00000000 00000160 1 0
00114463 00000160 1 0 00 00000000 00000168 0 0
00115463 00000164 0 0 00 00000000 00000168 0 0
0020E463 00000168 0 0 00 00000000 00000170 1 0
00117663 0000016C 1 0 00 00000000 00000178 0 0
02000BEF 00000170 1 1 17 00000174 00000190 0 0
00208C67 00000174 0 1 18 00000178 00000006 1 0
0000000B 00000178 0 0 00 00000000 0000017C 0 1
00100073 0000017C 0 0 00 00000000 00000180 0 4

// ==== build.f ====
rtl/rv32_pkg.sv
rtl/control_unit.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/branch_res.sv
rtl/load_store_unit.sv
rtl/execute_stage.sv
rtl/data_ram.sv
rtl/exec_subsystem_top.sv
tb/tb_exec.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_exec
FILELIST  := build.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qxF '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
